//--- Bender.yml
package:
  name: decode_stage

sources:
  - src/id_pkg.sv
  - src/id_stage_latch.sv
  - src/inst_decoder.sv
  - src/imm_gen.sv
  - src/operand_read.sv
  - src/decode_stage.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_decode_stage.sv

//--- sim/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected view of one decoded word
typedef struct packed {
	logic    ctrl_valid;
	logic    mem_op;
	alu_op_t alu_op;
	word_t   imm;
	raddr_t  raddr1;
	raddr_t  raddr2;
	raddr_t  dest;
	logic    src1_is_pc;
	logic    src2_is_imm;
	logic    src2_is_4;
	logic    br_src_sel;
	logic    br_sure;
	logic    br_yes;
	logic    br_no;
	logic    res_from_mem;
	logic    gpr_we;
	logic    mem_we;
	logic    ren1;
	logic    ren2;
	logic    byte_we;
	logic    half_we;
	logic    word_we;
	logic    signed_we;
	ecode_t  ecode;
	word_t   pc;
} dec_exp_t;

// class codes: 0 unknown, 1 3r, 2 reg-imm, 3 lu/pcadd, 4 load, 5 store
// 6 cond branch, 7 jirl, 8 b, 9 bl, 10 syscall, 11 break
function automatic dec_exp_t decode_ref(input word_t inst, input word_t pc, input ecode_t ec);
	dec_exp_t r;
	int cls;
	int op;
	int kind;
	int sz;
	logic sgn;
	logic taken_eq;
	logic pcadd;
	r = '0;
	cls = 0;
	op = -1;
	kind = 0;
	sz = 0;
	sgn = 1'b1;
	taken_eq = 1'b0;
	pcadd = 1'b0;
	// 3r, shift-immediate, syscall and break by the 17-bit opcode
	case (inst[31:15])
		17'h00020: begin cls = 1; op = op_add; end
		17'h00022: begin cls = 1; op = op_sub; end
		17'h00024: begin cls = 1; op = op_slt; end
		17'h00025: begin cls = 1; op = op_sltu; end
		17'h00028: begin cls = 1; op = op_nor; end
		17'h00029: begin cls = 1; op = op_and; end
		17'h0002a: begin cls = 1; op = op_or; end
		17'h0002b: begin cls = 1; op = op_xor; end
		17'h0002e: begin cls = 1; op = op_sll; end
		17'h0002f: begin cls = 1; op = op_srl; end
		17'h00030: begin cls = 1; op = op_sra; end
		17'h00081: begin cls = 2; op = op_sll; kind = 1; end
		17'h00089: begin cls = 2; op = op_srl; kind = 1; end
		17'h00091: begin cls = 2; op = op_sra; kind = 1; end
		17'h00056: cls = 10;
		17'h00054: cls = 11;
		default: ;
	endcase
	// 12-bit immediate forms, loads and stores
	if (cls == 0) begin
		case (inst[31:22])
			10'h008: begin cls = 2; op = op_slt; kind = 1; end
			10'h009: begin cls = 2; op = op_sltu; kind = 1; end
			10'h00a: begin cls = 2; op = op_add; kind = 1; end
			10'h00d: begin cls = 2; op = op_and; kind = 2; end
			10'h00e: begin cls = 2; op = op_or; kind = 2; end
			10'h00f: begin cls = 2; op = op_xor; kind = 2; end
			10'h0a0: begin cls = 4; sz = 0; end
			10'h0a1: begin cls = 4; sz = 1; end
			10'h0a2: begin cls = 4; sz = 2; end
			10'h0a8: begin cls = 4; sz = 0; sgn = 1'b0; end
			10'h0a9: begin cls = 4; sz = 1; sgn = 1'b0; end
			10'h0a4: begin cls = 5; sz = 0; end
			10'h0a5: begin cls = 5; sz = 1; end
			10'h0a6: begin cls = 5; sz = 2; end
			default: ;
		endcase
	end
	if (cls == 0) begin
		case (inst[31:25])
			7'h0a: begin cls = 3; op = op_lui; end
			7'h0e: begin cls = 3; op = op_add; pcadd = 1'b1; end
			default: ;
		endcase
	end
	// branches and jumps
	if (cls == 0) begin
		case (inst[31:26])
			6'h13: begin cls = 7; op = op_add; end
			6'h14: cls = 8;
			6'h15: begin cls = 9; op = op_add; end
			6'h16: begin cls = 6; op = op_eq; taken_eq = 1'b1; end
			6'h17: begin cls = 6; op = op_eq; end
			6'h18: begin cls = 6; op = op_slt; taken_eq = 1'b1; end
			6'h19: begin cls = 6; op = op_slt; end
			6'h1a: begin cls = 6; op = op_sltu; taken_eq = 1'b1; end
			6'h1b: begin cls = 6; op = op_sltu; end
			default: ;
		endcase
	end
	if (cls == 4 || cls == 5) begin
		op = op_add;
		kind = 1;
	end
	if (cls == 3)
		kind = 4;
	if (cls == 6 || cls == 7)
		kind = 3;
	if (cls == 8 || cls == 9)
		kind = 5;
	if (op >= 0)
		r.alu_op[op] = 1'b1;
	case (kind)
		1: r.imm = {{20{inst[21]}}, inst[21:10]};
		2: r.imm = {20'h0, inst[21:10]};
		3: r.imm = {{14{inst[25]}}, inst[25:10], 2'b00};
		4: r.imm = {inst[24:5], 12'h000};
		5: r.imm = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
		default: r.imm = '0;
	endcase
	r.raddr1 = inst[9:5];
	// cond branches and stores read rd as second operand
	r.raddr2 = (cls == 5 || cls == 6) ? inst[4:0] : inst[14:10];
	r.dest = (cls == 9) ? reg_ra : inst[4:0];
	r.src1_is_pc = (cls == 7) || (cls == 9) || pcadd;
	r.src2_is_imm = (cls >= 2) && (cls <= 5);
	r.src2_is_4 = (cls == 7) || (cls == 9);
	r.br_src_sel = (cls == 7);
	r.br_sure = (cls >= 7) && (cls <= 9);
	r.br_yes = (cls == 6) && taken_eq;
	r.br_no = (cls == 6) && !taken_eq;
	r.res_from_mem = (cls == 4);
	r.mem_we = (cls == 5);
	r.gpr_we = (cls >= 1 && cls <= 4) || cls == 7 || cls == 9;
	r.ren1 = (cls >= 1 && cls <= 7) && cls != 3;
	r.ren2 = (cls == 1) || (cls == 5) || (cls == 6);
	r.byte_we = (sz == 0);
	r.half_we = (sz == 1);
	r.word_we = (sz == 2);
	r.signed_we = sgn;
	r.mem_op = (cls == 4) || (cls == 5);
	r.ctrl_valid = (cls != 0) && (cls < 10);
	// earlier stage exception has priority
	if (ec != ecode_none)
		r.ecode = ec;
	else if (cls == 10)
		r.ecode = ecode_sys;
	else if (cls == 11)
		r.ecode = ecode_brk;
	else if (cls == 0)
		r.ecode = ecode_ine;
	else
		r.ecode = ecode_none;
	r.pc = pc;
	return r;
endfunction

`endif

//--- sim/tb_decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_decode_stage;
	import id_pkg::*;

	`include "decode_model.svh"

	logic clk;
	logic rst;
	logic load;
	word_t inst_in;
	word_t pc_in;
	ecode_t ecode_in;
	logic rf_we;
	raddr_t rf_waddr;
	word_t rf_wdata;
	logic fwd_ex_r1, fwd_mem_r1, fwd_wb_r1;
	logic fwd_ex_r2, fwd_mem_r2, fwd_wb_r2;
	word_t ex_result, mem_result, wb_result;
	word_t pc_id, imm, rj_value, rkd_value;
	alu_op_t alu_op;
	raddr_t rf_raddr1, rf_raddr2, dest;
	logic src1_is_pc, src2_is_imm, src2_is_4, br_src_sel;
	logic br_taken_sure, br_taken_yes, br_taken_no;
	logic res_from_mem, gpr_we, mem_we, rf_ren1, rf_ren2;
	logic byte_we, half_we, word_we, signed_we;
	ecode_t ecode_id;

	integer seed = 86846;
	integer err_cnt = 0;
	integer chk_cnt = 0;
	integer chk_req = 0;
	integer chk_ack = 0;
	dec_exp_t exp_dec;
	word_t rf_mirror [32];

	// one legal encoding per kept instruction with all fields zero
	word_t legal_base [39] = '{
		32'h00100000, 32'h00110000, 32'h00120000, 32'h00128000,
		32'h00140000, 32'h00148000, 32'h00150000, 32'h00158000,
		32'h00170000, 32'h00178000, 32'h00180000,
		32'h00408000, 32'h00448000, 32'h00488000,
		32'h02000000, 32'h02400000, 32'h02800000, 32'h03400000,
		32'h03800000, 32'h03c00000, 32'h14000000, 32'h1c000000,
		32'h4c000000, 32'h50000000, 32'h54000000, 32'h58000000,
		32'h5c000000, 32'h60000000, 32'h64000000, 32'h68000000,
		32'h6c000000,
		32'h28000000, 32'h28400000, 32'h28800000, 32'h2a000000,
		32'h2a400000, 32'h29000000, 32'h29400000, 32'h29800000
	};

	// syscall, break, reserved sub-encodings, then dropped classes
	word_t bad_word [25] = '{
		32'h002b0000, 32'h002a0000,
		32'h40000000, 32'h70000000, 32'h28c00000, 32'h2b800000,
		32'h2b000000, 32'h29c00000, 32'h02c00000, 32'h03000000,
		32'h00418000, 32'h004c8000, 32'h00108000, 32'h00118000,
		32'h00130000, 32'h00138000, 32'h00160000, 32'h00168000,
		32'h04000000, 32'h001c0000, 32'h00200000, 32'h06483800,
		32'h00006000, 32'h06482800, 32'h06000000
	};

	decode_stage i_decode_stage (
		.clk           (clk),
		.rst           (rst),
		.load          (load),
		.inst_in       (inst_in),
		.pc_in         (pc_in),
		.ecode_in      (ecode_in),
		.rf_we         (rf_we),
		.rf_waddr      (rf_waddr),
		.rf_wdata      (rf_wdata),
		.fwd_ex_r1     (fwd_ex_r1),
		.fwd_mem_r1    (fwd_mem_r1),
		.fwd_wb_r1     (fwd_wb_r1),
		.fwd_ex_r2     (fwd_ex_r2),
		.fwd_mem_r2    (fwd_mem_r2),
		.fwd_wb_r2     (fwd_wb_r2),
		.ex_result     (ex_result),
		.mem_result    (mem_result),
		.wb_result     (wb_result),
		.pc_id         (pc_id),
		.alu_op        (alu_op),
		.imm           (imm),
		.rj_value      (rj_value),
		.rkd_value     (rkd_value),
		.rf_raddr1     (rf_raddr1),
		.rf_raddr2     (rf_raddr2),
		.dest          (dest),
		.src1_is_pc    (src1_is_pc),
		.src2_is_imm   (src2_is_imm),
		.src2_is_4     (src2_is_4),
		.br_src_sel    (br_src_sel),
		.br_taken_sure (br_taken_sure),
		.br_taken_yes  (br_taken_yes),
		.br_taken_no   (br_taken_no),
		.res_from_mem  (res_from_mem),
		.gpr_we        (gpr_we),
		.mem_we        (mem_we),
		.rf_ren1       (rf_ren1),
		.rf_ren2       (rf_ren2),
		.byte_we       (byte_we),
		.half_we       (half_we),
		.word_we       (word_we),
		.signed_we     (signed_we),
		.ecode_id      (ecode_id)
	);

	always #10 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] act,
		input logic [31:0] exp);
		chk_cnt++;
		if (act !== exp) begin
			$display("mismatch %s: got %h expected %h", name, act, exp);
			err_cnt++;
		end
	endtask

	// ex > mem > wb > register file
	function automatic word_t fwd_expect(input logic ex, input logic mem, input logic wb,
		input word_t rf_val);
		if (ex)
			return ex_result;
		if (mem)
			return mem_result;
		if (wb)
			return wb_result;
		return rf_val;
	endfunction

	// field bits that may be randomized for a legal base word
	// shift-immediates keep bits 21:15 as opcode
	function automatic word_t field_mask(input word_t base);
		if (base[31:30] == 2'b01)
			return 32'h03ffffff;
		if (base[31:28] == 4'h1)
			return 32'h01ffffff;
		if (base[31:23] != 9'h0)
			return 32'h003fffff;
		return 32'h00007fff;
	endfunction

	// comparison process samples just before the edge updates anything
	always @(posedge clk) begin
		if (chk_ack != chk_req) begin
			check_value("pc_id", pc_id, exp_dec.pc);
			check_value("ecode_id", ecode_id, exp_dec.ecode);
			if (exp_dec.ctrl_valid) begin
				check_value("alu_op", alu_op, exp_dec.alu_op);
				check_value("imm", imm, exp_dec.imm);
				check_value("rf_raddr1", rf_raddr1, exp_dec.raddr1);
				check_value("rf_raddr2", rf_raddr2, exp_dec.raddr2);
				check_value("dest", dest, exp_dec.dest);
				check_value("src1_is_pc", src1_is_pc, exp_dec.src1_is_pc);
				check_value("src2_is_imm", src2_is_imm, exp_dec.src2_is_imm);
				check_value("src2_is_4", src2_is_4, exp_dec.src2_is_4);
				check_value("br_src_sel", br_src_sel, exp_dec.br_src_sel);
				check_value("br_taken_sure", br_taken_sure, exp_dec.br_sure);
				check_value("br_taken_yes", br_taken_yes, exp_dec.br_yes);
				check_value("br_taken_no", br_taken_no, exp_dec.br_no);
				check_value("res_from_mem", res_from_mem, exp_dec.res_from_mem);
				check_value("gpr_we", gpr_we, exp_dec.gpr_we);
				check_value("mem_we", mem_we, exp_dec.mem_we);
				check_value("rf_ren1", rf_ren1, exp_dec.ren1);
				check_value("rf_ren2", rf_ren2, exp_dec.ren2);
				check_value("rj_value", rj_value, fwd_expect(fwd_ex_r1, fwd_mem_r1,
					fwd_wb_r1, rf_mirror[exp_dec.raddr1]));
				check_value("rkd_value", rkd_value, fwd_expect(fwd_ex_r2, fwd_mem_r2,
					fwd_wb_r2, rf_mirror[exp_dec.raddr2]));
			end
			if (exp_dec.mem_op) begin
				check_value("byte_we", byte_we, exp_dec.byte_we);
				check_value("half_we", half_we, exp_dec.half_we);
				check_value("word_we", word_we, exp_dec.word_we);
				check_value("signed_we", signed_we, exp_dec.signed_we);
			end
			chk_ack = chk_req;
		end
	end

	// hand one check to the comparison process and wait for it
	task automatic issue_check();
		integer n;
		n = 0;
		chk_req++;
		while (chk_ack != chk_req && n < 10) begin
			@(negedge clk);
			n++;
		end
		if (chk_ack != chk_req) begin
			$display("timeout: comparison process did not answer a check request");
			err_cnt++;
			chk_ack = chk_req;
		end
	endtask

	// one-cycle load strobe and then scramble inst_in
	task automatic load_inst(input word_t w, input word_t pc, input ecode_t ec);
		@(negedge clk);
		inst_in = w;
		pc_in = pc;
		ecode_in = ec;
		load = 1'b1;
		@(negedge clk);
		load = 1'b0;
		inst_in = $random(seed);
		exp_dec = decode_ref(w, pc, ec);
	endtask

	task automatic write_reg(input raddr_t a, input word_t d);
		@(negedge clk);
		rf_we = 1'b1;
		rf_waddr = a;
		rf_wdata = d;
		@(negedge clk);
		rf_we = 1'b0;
		if (a != reg_zero)
			rf_mirror[a] = d;
	endtask

	task automatic clear_fwd();
		{fwd_ex_r1, fwd_mem_r1, fwd_wb_r1} = 3'b000;
		{fwd_ex_r2, fwd_mem_r2, fwd_wb_r2} = 3'b000;
	endtask

	initial begin
		word_t w;
		ecode_t ec;
		clk = 1'b0;
		rst = 1'b1;
		load = 1'b0;
		inst_in = '0;
		pc_in = '0;
		ecode_in = '0;
		rf_we = 1'b0;
		rf_waddr = '0;
		rf_wdata = '0;
		clear_fwd();
		ex_result = '0;
		mem_result = '0;
		wb_result = '0;
		for (int i = 0; i < 32; i++)
			rf_mirror[i] = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// reset state is benign
		@(negedge clk);
		check_value("mem_we", mem_we, 1'b0);
		check_value("res_from_mem", res_from_mem, 1'b0);
		check_value("br_taken_sure", br_taken_sure, 1'b0);
		check_value("br_taken_yes", br_taken_yes, 1'b0);
		check_value("br_taken_no", br_taken_no, 1'b0);
		check_value("ecode_id", ecode_id, ecode_none);

		// fill every register including r0 which must keep reading zero
		for (int i = 0; i < 32; i++)
			write_reg(i[4:0], $random(seed));
		for (int i = 0; i < 32; i++) begin
			w = 32'h00100000 | (i << 5) | ((31 - i) << 10) | ($random(seed) & 32'h1f);
			load_inst(w, $random(seed), ecode_none);
			issue_check();
		end
		for (int i = 0; i < 20; i++)
			write_reg($random(seed), $random(seed));
		for (int i = 0; i < 16; i++) begin
			load_inst(32'h00100000 | ($random(seed) & 32'h7fff), $random(seed), ecode_none);
			issue_check();
		end

		// legal table with random fields
		for (int rep = 0; rep < 3; rep++) begin
			foreach (legal_base[k]) begin
				w = legal_base[k] | ($random(seed) & field_mask(legal_base[k]));
				load_inst(w, $random(seed), ecode_none);
				issue_check();
			end
		end

		// exception codes first and the same words with an earlier exception next
		for (int pass = 0; pass < 2; pass++) begin
			foreach (bad_word[k]) begin
				w = bad_word[k];
				if (k < 2)
					w = w | ($random(seed) & 32'h7fff);
				ec = (pass == 0) ? ecode_none : (($random(seed) & 6'h3f) | 6'h01);
				load_inst(w, $random(seed), ec);
				issue_check();
			end
			for (int i = 0; i < 8; i++) begin
				ec = (pass == 0) ? ecode_none : (($random(seed) & 6'h3f) | 6'h01);
				load_inst($random(seed) | 32'h80000000, $random(seed), ec);
				issue_check();
			end
		end

		// forwarding priority
		for (int i = 0; i < 40; i++) begin
			load_inst(32'h00100000 | ($random(seed) & 32'h7fff), $random(seed), ecode_none);
			{fwd_ex_r1, fwd_mem_r1, fwd_wb_r1} = $random(seed);
			{fwd_ex_r2, fwd_mem_r2, fwd_wb_r2} = $random(seed);
			ex_result = $random(seed);
			mem_result = $random(seed);
			wb_result = $random(seed);
			issue_check();
			clear_fwd();
		end

		// hold with load low while inputs move
		for (int i = 0; i < 4; i++) begin
			w = legal_base[$unsigned($random(seed)) % 39];
			load_inst(w | ($random(seed) & field_mask(w)), $random(seed), ecode_none);
			issue_check();
			repeat (6) begin
				inst_in = $random(seed);
				pc_in = $random(seed);
				ecode_in = $random(seed);
				issue_check();
			end
			// the last changed inputs have met one more edge
			issue_check();
		end

		$display("checks %0d errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+sim
src/id_pkg.sv
src/id_stage_latch.sv
src/inst_decoder.sv
src/imm_gen.sv
src/operand_read.sv
src/decode_stage.sv
sim/tb_decode_stage.sv

//--- src/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
	input  logic            clk,
	input  logic            rst,
	input  logic            load,
	input  id_pkg::word_t   inst_in,
	input  id_pkg::word_t   pc_in,
	input  id_pkg::ecode_t  ecode_in,
	input  logic            rf_we,
	input  id_pkg::raddr_t  rf_waddr,
	input  id_pkg::word_t   rf_wdata,
	input  logic            fwd_ex_r1,
	input  logic            fwd_mem_r1,
	input  logic            fwd_wb_r1,
	input  logic            fwd_ex_r2,
	input  logic            fwd_mem_r2,
	input  logic            fwd_wb_r2,
	input  id_pkg::word_t   ex_result,
	input  id_pkg::word_t   mem_result,
	input  id_pkg::word_t   wb_result,
	output id_pkg::word_t   pc_id,
	output id_pkg::alu_op_t alu_op,
	output id_pkg::word_t   imm,
	output id_pkg::word_t   rj_value,
	output id_pkg::word_t   rkd_value,
	output id_pkg::raddr_t  rf_raddr1,
	output id_pkg::raddr_t  rf_raddr2,
	output id_pkg::raddr_t  dest,
	output logic            src1_is_pc,
	output logic            src2_is_imm,
	output logic            src2_is_4,
	output logic            br_src_sel,
	output logic            br_taken_sure,
	output logic            br_taken_yes,
	output logic            br_taken_no,
	output logic            res_from_mem,
	output logic            gpr_we,
	output logic            mem_we,
	output logic            rf_ren1,
	output logic            rf_ren2,
	output logic            byte_we,
	output logic            half_we,
	output logic            word_we,
	output logic            signed_we,
	output id_pkg::ecode_t  ecode_id
);
	import id_pkg::*;

	// latched word and code, and decoder to immgen select
	word_t     inst_id;
	ecode_t    ecode_latched;
	imm_kind_t imm_kind;

	id_stage_latch i_id_stage_latch (
		.clk           (clk),
		.rst           (rst),
		.load          (load),
		.inst_in       (inst_in),
		.pc_in         (pc_in),
		.ecode_in      (ecode_in),
		.inst_id       (inst_id),
		.pc_id         (pc_id),
		.ecode_latched (ecode_latched)
	);

	inst_decoder i_inst_decoder (
		.inst_id       (inst_id),
		.ecode_latched (ecode_latched),
		.alu_op        (alu_op),
		.imm_kind      (imm_kind),
		.rf_raddr1     (rf_raddr1),
		.rf_raddr2     (rf_raddr2),
		.dest          (dest),
		.src1_is_pc    (src1_is_pc),
		.src2_is_imm   (src2_is_imm),
		.src2_is_4     (src2_is_4),
		.br_src_sel    (br_src_sel),
		.br_taken_sure (br_taken_sure),
		.br_taken_yes  (br_taken_yes),
		.br_taken_no   (br_taken_no),
		.res_from_mem  (res_from_mem),
		.gpr_we        (gpr_we),
		.mem_we        (mem_we),
		.rf_ren1       (rf_ren1),
		.rf_ren2       (rf_ren2),
		.byte_we       (byte_we),
		.half_we       (half_we),
		.word_we       (word_we),
		.signed_we     (signed_we),
		.ecode_id      (ecode_id)
	);

	imm_gen i_imm_gen (
		.inst_id  (inst_id),
		.imm_kind (imm_kind),
		.imm      (imm)
	);

	// read addresses come from the decoder
	operand_read i_operand_read (
		.clk        (clk),
		.rf_raddr1  (rf_raddr1),
		.rf_raddr2  (rf_raddr2),
		.rf_we      (rf_we),
		.rf_waddr   (rf_waddr),
		.rf_wdata   (rf_wdata),
		.fwd_ex_r1  (fwd_ex_r1),
		.fwd_mem_r1 (fwd_mem_r1),
		.fwd_wb_r1  (fwd_wb_r1),
		.fwd_ex_r2  (fwd_ex_r2),
		.fwd_mem_r2 (fwd_mem_r2),
		.fwd_wb_r2  (fwd_wb_r2),
		.ex_result  (ex_result),
		.mem_result (mem_result),
		.wb_result  (wb_result),
		.rj_value   (rj_value),
		.rkd_value  (rkd_value)
	);

endmodule

`default_nettype wire

//--- src/id_pkg.sv
`default_nettype none

package id_pkg;

	// datapath and register number widths
	localparam int word_w  = 32;
	localparam int raddr_w = 5;

	typedef logic [word_w-1:0]  word_t;
	typedef logic [raddr_w-1:0] raddr_t;
	// exception code as carried down the pipe
	typedef logic [5:0]         ecode_t;

	// one-hot alu operation vector
	localparam int alu_op_w = 13;
	typedef logic [alu_op_w-1:0] alu_op_t;

	// bit positions inside alu_op_t
	localparam int op_add  = 0;
	localparam int op_sub  = 1;
	localparam int op_slt  = 2;
	localparam int op_sltu = 3;
	localparam int op_and  = 4;
	localparam int op_nor  = 5;
	localparam int op_or   = 6;
	localparam int op_xor  = 7;
	localparam int op_sll  = 8;
	localparam int op_srl  = 9;
	localparam int op_sra  = 10;
	localparam int op_lui  = 11;
	localparam int op_eq   = 12;

	// immediate formats
	// shift-immediates use si12, ALU only looks at the low five bits
	typedef enum logic [2:0] {
		imm_none,
		imm_si12,
		imm_ui12,
		imm_si16,
		imm_si20,
		imm_si26
	} imm_kind_t;

	// exception codes
	localparam ecode_t ecode_none = 6'h00;
	localparam ecode_t ecode_sys  = 6'h0b;
	localparam ecode_t ecode_brk  = 6'h0c;
	localparam ecode_t ecode_ine  = 6'h0d;

	// fixed register numbers
	localparam raddr_t reg_zero = 5'd0;
	localparam raddr_t reg_ra   = 5'd1;

	// andi r0, r0, 0
	localparam word_t nop_word = 32'h0340_0000;

endpackage

`default_nettype wire

//--- src/id_stage_latch.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage_latch (
	input  logic           clk,
	input  logic           rst,
	input  logic           load,
	input  id_pkg::word_t  inst_in,
	input  id_pkg::word_t  pc_in,
	input  id_pkg::ecode_t ecode_in,
	output id_pkg::word_t  inst_id,
	output id_pkg::word_t  pc_id,
	output id_pkg::ecode_t ecode_latched
);
	import id_pkg::*;

	// if -> id pipeline register
	// all three fields move together on load
	always_ff @(posedge clk) begin
		if (rst) begin
			// nop keeps downstream control quiet
			inst_id       <= nop_word;
			pc_id         <= '0;
			ecode_latched <= ecode_none;
		end else if (load) begin
			inst_id       <= inst_in;
			pc_id         <= pc_in;
			ecode_latched <= ecode_in;
		end
		// load low: hold current instruction
	end

endmodule

`default_nettype wire

//--- src/imm_gen.sv
`timescale 1ns/10ps
`default_nettype none

module imm_gen (
	input  id_pkg::word_t     inst_id,
	input  id_pkg::imm_kind_t imm_kind,
	output id_pkg::word_t     imm
);
	import id_pkg::*;

	// raw immediate fields
	logic [11:0] imm12;
	logic [15:0] imm16;
	logic [19:0] imm20;
	logic [25:0] imm26;
	assign imm12 = inst_id[21:10];
	assign imm16 = inst_id[25:10];
	assign imm20 = inst_id[24:5];
	// offs26 is split, high part sits in the low bits
	assign imm26 = {inst_id[9:0], inst_id[25:10]};

	always_comb begin
		case (imm_kind)
			// also covers ui5 of the shifts
			imm_si12: imm = {{20{imm12[11]}}, imm12};
			imm_ui12: imm = {20'b0, imm12};
			// branch offsets are word aligned
			imm_si16: imm = {{14{imm16[15]}}, imm16, 2'b00};
			// upper twenty for lu12i.w and pcaddu12i
			imm_si20: imm = {imm20, 12'b0};
			imm_si26: imm = {{4{imm26[25]}}, imm26, 2'b00};
			default:  imm = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- src/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
	input  id_pkg::word_t     inst_id,
	input  id_pkg::ecode_t    ecode_latched,
	output id_pkg::alu_op_t   alu_op,
	output id_pkg::imm_kind_t imm_kind,
	output id_pkg::raddr_t    rf_raddr1,
	output id_pkg::raddr_t    rf_raddr2,
	output id_pkg::raddr_t    dest,
	output logic              src1_is_pc,
	output logic              src2_is_imm,
	output logic              src2_is_4,
	output logic              br_src_sel,
	output logic              br_taken_sure,
	output logic              br_taken_yes,
	output logic              br_taken_no,
	output logic              res_from_mem,
	output logic              gpr_we,
	output logic              mem_we,
	output logic              rf_ren1,
	output logic              rf_ren2,
	output logic              byte_we,
	output logic              half_we,
	output logic              word_we,
	output logic              signed_we,
	output id_pkg::ecode_t    ecode_id
);
	import id_pkg::*;

	// opcode fields
	logic [5:0] op_31_26;
	logic [3:0] op_25_22;
	logic [6:0] op_21_15;
	assign op_31_26 = inst_id[31:26];
	assign op_25_22 = inst_id[25:22];
	assign op_21_15 = inst_id[21:15];

	// register number fields
	raddr_t rd;
	raddr_t rj;
	raddr_t rk;
	assign rd = inst_id[4:0];
	assign rj = inst_id[9:5];
	assign rk = inst_id[14:10];

	// bit 31 is never set in a kept encoding
	logic top_ok;
	logic op30_26_0;
	logic op30_22_0;
	assign top_ok    = !op_31_26[5];
	assign op30_26_0 = top_ok && (op_31_26[4:0] == 5'b00000);
	assign op30_22_0 = op30_26_0 && (op_25_22 == 4'b0000);

	// class detection
	logic br_inst, ld_inst, st_inst, lu_inst, alui_inst, sfti_inst;
	logic sftr_inst, alur_inst, syscall_inst, break_inst;
	assign br_inst      = top_ok && op_31_26[4];
	assign ld_inst      = top_ok && (op_31_26[4:0] == 5'b01010) && !op_25_22[2];
	assign st_inst      = top_ok && (op_31_26[4:0] == 5'b01010) && op_25_22[2];
	assign lu_inst      = top_ok && (op_31_26[4:2] == 3'b001);
	assign alui_inst    = op30_26_0 && op_25_22[3];
	assign sfti_inst    = op30_26_0 && (op_25_22 == 4'b0001);
	assign syscall_inst = op30_22_0 && (op_21_15 == 7'b1010110);
	assign break_inst   = op30_22_0 && (op_21_15 == 7'b1010100);
	// sll.w srl.w sra.w sit inside the 3r alu range
	assign sftr_inst    = op30_22_0 && ((op_21_15 == 7'b0110000) ||
		(op_21_15[6:1] == 6'b010111));
	assign alur_inst    = op30_22_0 && (op_21_15[6:4] == 3'b010) && !sftr_inst;

	// reserved sub-encodings inside the kept classes
	logic br_ill, ld_ill, st_ill, lu_ill, alui_ill, sfti_ill, alur_ill;
	logic known_inst, illegal_inst;
	// only jirl (3) through bgeu (11) exist
	assign br_ill   = br_inst && ((op_31_26[3:0] <= 4'd2) || (op_31_26[3:0] >= 4'd12));
	assign ld_ill   = ld_inst && (({op_25_22[3], op_25_22[1:0]} == 3'b011) ||
		({op_25_22[3], op_25_22[1:0]} >= 3'b110));
	assign st_ill   = st_inst && (op_25_22[3] || (op_25_22[1:0] == 2'b11));
	// only lu12i.w and pcaddu12i, both with bit 25 clear
	assign lu_ill   = lu_inst && (!op_31_26[0] || op_25_22[3]);
	assign alui_ill = alui_inst && ((op_25_22[2:0] == 3'd3) || (op_25_22[2:0] == 3'd4));
	assign sfti_ill = sfti_inst && (({op_21_15[6:5], op_21_15[2:0]} != 5'b00001) ||
		(op_21_15[4:3] == 2'b11));
	assign alur_ill = alur_inst && ((op_21_15[3:0] == 4'd1) || (op_21_15[3:0] == 4'd3) ||
		(op_21_15[3:0] == 4'd6) || (op_21_15[3:0] == 4'd7) ||
		(op_21_15[3:0] == 4'd12) || (op_21_15[3:0] == 4'd13));

	assign known_inst = br_inst || ld_inst || st_inst || lu_inst || alui_inst ||
		sfti_inst || sftr_inst || alur_inst || syscall_inst || break_inst;
	// anything else, csr/tlb/mul/div included, is illegal now
	assign illegal_inst = !top_ok || !known_inst || br_ill || ld_ill || st_ill ||
		lu_ill || alui_ill || sfti_ill || alur_ill;

	// 3r register instructions
	logic inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_nor, inst_and, inst_or, inst_xor;
	logic inst_sll_w, inst_srl_w, inst_sra_w;
	assign inst_add_w = alur_inst && (op_21_15[3:1] == 3'b000);
	assign inst_sub_w = alur_inst && (op_21_15[3:1] == 3'b001);
	assign inst_slt   = alur_inst && ({op_21_15[2], op_21_15[0]} == 2'b10);
	assign inst_sltu  = alur_inst && ({op_21_15[2], op_21_15[0]} == 2'b11);
	assign inst_nor   = alur_inst && ({op_21_15[3], op_21_15[1:0]} == 3'b100);
	assign inst_and   = alur_inst && ({op_21_15[3], op_21_15[1:0]} == 3'b101);
	assign inst_or    = alur_inst && ({op_21_15[3], op_21_15[1:0]} == 3'b110);
	assign inst_xor   = alur_inst && ({op_21_15[3], op_21_15[1:0]} == 3'b111);
	assign inst_sll_w = sftr_inst && (op_21_15[1:0] == 2'b10);
	assign inst_srl_w = sftr_inst && (op_21_15[1:0] == 2'b11);
	assign inst_sra_w = sftr_inst && (op_21_15[1:0] == 2'b00);

	// immediate forms
	logic inst_slli_w, inst_srli_w, inst_srai_w, inst_slti, inst_sltui, inst_addi_w;
	logic inst_andi, inst_ori, inst_xori, inst_lu12i_w, inst_pcaddu12i;
	assign inst_slli_w    = sfti_inst && (op_21_15[4:3] == 2'b00);
	assign inst_srli_w    = sfti_inst && (op_21_15[4:3] == 2'b01);
	assign inst_srai_w    = sfti_inst && (op_21_15[4:3] == 2'b10);
	assign inst_slti      = alui_inst && (op_25_22[2:0] == 3'd0);
	assign inst_sltui     = alui_inst && (op_25_22[2:0] == 3'd1);
	assign inst_addi_w    = alui_inst && (op_25_22[2:0] == 3'd2);
	assign inst_andi      = alui_inst && (op_25_22[2:0] == 3'd5);
	assign inst_ori       = alui_inst && (op_25_22[2:0] == 3'd6);
	assign inst_xori      = alui_inst && (op_25_22[2:0] == 3'd7);
	assign inst_lu12i_w   = lu_inst && !op_31_26[1];
	assign inst_pcaddu12i = lu_inst && op_31_26[1];

	// branches and jumps by low opcode nibble
	logic inst_jirl, inst_b, inst_bl, inst_beq, inst_bne, inst_blt, inst_bge;
	logic inst_bltu, inst_bgeu;
	assign inst_jirl = br_inst && (op_31_26[3:0] == 4'd3);
	assign inst_b    = br_inst && (op_31_26[3:0] == 4'd4);
	assign inst_bl   = br_inst && (op_31_26[3:0] == 4'd5);
	assign inst_beq  = br_inst && (op_31_26[3:0] == 4'd6);
	assign inst_bne  = br_inst && (op_31_26[3:0] == 4'd7);
	assign inst_blt  = br_inst && (op_31_26[3:0] == 4'd8);
	assign inst_bge  = br_inst && (op_31_26[3:0] == 4'd9);
	assign inst_bltu = br_inst && (op_31_26[3:0] == 4'd10);
	assign inst_bgeu = br_inst && (op_31_26[3:0] == 4'd11);

	// address calc and link use the adder too
	assign alu_op[op_add]  = inst_add_w || inst_addi_w || ld_inst || st_inst ||
		inst_jirl || inst_bl || inst_pcaddu12i;
	assign alu_op[op_sub]  = inst_sub_w;
	// compare-and-branch reuse the slt units
	assign alu_op[op_slt]  = inst_slt || inst_slti || inst_blt || inst_bge;
	assign alu_op[op_sltu] = inst_sltu || inst_sltui || inst_bltu || inst_bgeu;
	assign alu_op[op_and]  = inst_and || inst_andi;
	assign alu_op[op_nor]  = inst_nor;
	assign alu_op[op_or]   = inst_or || inst_ori;
	assign alu_op[op_xor]  = inst_xor || inst_xori;
	assign alu_op[op_sll]  = inst_sll_w || inst_slli_w;
	assign alu_op[op_srl]  = inst_srl_w || inst_srli_w;
	assign alu_op[op_sra]  = inst_sra_w || inst_srai_w;
	assign alu_op[op_lui]  = inst_lu12i_w;
	assign alu_op[op_eq]   = inst_beq || inst_bne;

	// immediate format select, the needs never overlap
	always_comb begin
		imm_kind = imm_none;
		if (sfti_inst || inst_slti || inst_sltui || inst_addi_w || ld_inst || st_inst)
			imm_kind = imm_si12;
		else if (inst_andi || inst_ori || inst_xori)
			imm_kind = imm_ui12;
		else if (br_inst && !(inst_b || inst_bl))
			imm_kind = imm_si16;
		else if (lu_inst)
			imm_kind = imm_si20;
		else if (inst_b || inst_bl)
			imm_kind = imm_si26;
	end

	// branch condition class, resolved in ex
	assign br_taken_sure = inst_jirl || inst_b || inst_bl;
	assign br_taken_yes  = inst_beq || inst_blt || inst_bltu;
	assign br_taken_no   = inst_bne || inst_bge || inst_bgeu;

	// conditional branches and stores read rd as second source
	logic src_reg_is_rd;
	assign src_reg_is_rd = (br_inst && (op_31_26[3] || (op_31_26[2] && op_31_26[1]))) || st_inst;
	assign src1_is_pc    = inst_jirl || inst_bl || inst_pcaddu12i;
	assign src2_is_imm   = sfti_inst || alui_inst || ld_inst || st_inst || lu_inst;
	// link value is pc + 4
	assign src2_is_4     = inst_jirl || inst_bl;
	assign br_src_sel    = inst_jirl;

	assign rf_raddr1 = rj;
	assign rf_raddr2 = src_reg_is_rd ? rd : rk;
	// bl links into r1
	assign dest      = inst_bl ? reg_ra : rd;

	// write enables
	assign res_from_mem = ld_inst;
	assign mem_we       = st_inst;
	// stores and non-linking branches write nothing
	assign gpr_we       = !st_inst && !(br_inst && !inst_jirl && !inst_bl);

	// read enables for hazard detection
	assign rf_ren1 = (br_inst && !(inst_b || inst_bl)) || ld_inst || st_inst ||
		alui_inst || sfti_inst || sftr_inst || alur_inst;
	assign rf_ren2 = (br_inst && !(inst_jirl || inst_b || inst_bl)) || st_inst ||
		sftr_inst || alur_inst;

	// access size straight from the ld/st size field
	assign byte_we   = (op_25_22[1:0] == 2'b00);
	assign half_we   = op_25_22[0];
	assign word_we   = op_25_22[1];
	assign signed_we = !op_25_22[3];

	// earlier exception wins, then sys/brk/ine
	assign ecode_id = (ecode_latched != ecode_none) ? ecode_latched :
		syscall_inst ? ecode_sys :
		break_inst   ? ecode_brk :
		illegal_inst ? ecode_ine :
		ecode_none;

endmodule

`default_nettype wire

//--- src/operand_read.sv
`timescale 1ns/10ps
`default_nettype none

module operand_read (
	input  logic           clk,
	input  id_pkg::raddr_t rf_raddr1,
	input  id_pkg::raddr_t rf_raddr2,
	input  logic           rf_we,
	input  id_pkg::raddr_t rf_waddr,
	input  id_pkg::word_t  rf_wdata,
	input  logic           fwd_ex_r1,
	input  logic           fwd_mem_r1,
	input  logic           fwd_wb_r1,
	input  logic           fwd_ex_r2,
	input  logic           fwd_mem_r2,
	input  logic           fwd_wb_r2,
	input  id_pkg::word_t  ex_result,
	input  id_pkg::word_t  mem_result,
	input  id_pkg::word_t  wb_result,
	output id_pkg::word_t  rj_value,
	output id_pkg::word_t  rkd_value
);
	import id_pkg::*;

	// general register file, 32 x 32
	logic [word_w-1:0] gpr [2**raddr_w];

	word_t rf_rdata1;
	word_t rf_rdata2;

	// writeback port, r0 is never written
	always_ff @(posedge clk) begin
		if (rf_we && (rf_waddr != reg_zero))
			gpr[rf_waddr] <= rf_wdata;
	end

	// asynchronous reads, r0 forced to zero
	assign rf_rdata1 = (rf_raddr1 == reg_zero) ? '0 : gpr[rf_raddr1];
	assign rf_rdata2 = (rf_raddr2 == reg_zero) ? '0 : gpr[rf_raddr2];

	// priority ex > mem > wb > register file
	function automatic word_t fwd_pick(input logic sel_ex, input logic sel_mem,
		input logic sel_wb, input word_t rf_val);
		if (sel_ex)
			return ex_result;
		else if (sel_mem)
			return mem_result;
		else if (sel_wb)
			return wb_result;
		return rf_val;
	endfunction

	assign rj_value  = fwd_pick(fwd_ex_r1, fwd_mem_r1, fwd_wb_r1, rf_rdata1);
	assign rkd_value = fwd_pick(fwd_ex_r2, fwd_mem_r2, fwd_wb_r2, rf_rdata2);

endmodule

`default_nettype wire
